//--- verilog/minisys_io_pkg.sv
`default_nettype none

package minisys_io_pkg;

    localparam int IO_ADDR_W = 10;         // Offset inside the I/O page
    localparam int IO_DATA_W = 16;
    localparam int IO_REG_W  = 3;          // Register offset inside one block
    localparam int LED_W     = 24;
    localparam int SWITCH_W  = 24;
    localparam int TMR_NUM   = 2;          // Timer channels

    // Block numbers, offset bits 9 to 4
    localparam logic [5:0] BLK_TIMER  = 6'h02;  // 0x020
    localparam logic [5:0] BLK_PWM    = 6'h03;  // 0x030
    localparam logic [5:0] BLK_LED    = 6'h06;  // 0x060
    localparam logic [5:0] BLK_SWITCH = 6'h07;  // 0x070

    localparam logic [IO_REG_W-1:0] TMR_CTRL0 = 3'd0;
    localparam logic [IO_REG_W-1:0] TMR_CTRL1 = 3'd2;
    localparam logic [IO_REG_W-1:0] TMR_CNT0  = 3'd4;
    localparam logic [IO_REG_W-1:0] TMR_CNT1  = 3'd6;

    localparam logic [IO_REG_W-1:0] PWM_MAX  = 3'd0;
    localparam logic [IO_REG_W-1:0] PWM_CMP  = 3'd2;
    localparam logic [IO_REG_W-1:0] PWM_CTRL = 3'd4;

    localparam logic [IO_REG_W-1:0] LED_LO = 3'd0;   // Also the switch low half
    localparam logic [IO_REG_W-1:0] LED_HI = 3'd2;

    typedef enum logic [2:0] {IO_NONE, IO_LED, IO_SWITCH, IO_TIMER, IO_PWM} io_block_e;
    typedef enum logic {TMR_ONE_SHOT, TMR_REPEAT} timer_mode_e;
    typedef enum logic {TMR_IDLE, TMR_RUN} timer_state_e;

endpackage

`default_nettype wire

//--- verilog/io_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if;
    import minisys_io_pkg::*;

    io_block_e             sel;        // Decoded peripheral
    logic [IO_REG_W-1:0]   offset;
    logic [IO_DATA_W-1:0]  wdata;
    logic                  wr;
    logic                  rd;
    logic [IO_DATA_W-1:0]  sw_rdata;   // From the switch port
    logic [IO_DATA_W-1:0]  tmr_rdata;  // From the timer

    modport decoder (output sel, offset, wdata, wr, rd, input sw_rdata, tmr_rdata);
    modport ledsw   (input sel, offset, wdata, wr, output sw_rdata);
    modport timer   (input sel, offset, wdata, wr, rd, output tmr_rdata);
    modport pwm     (input sel, offset, wdata, wr);

endinterface

`default_nettype wire

//--- verilog/io_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_decoder (
    input  wire  [minisys_io_pkg::IO_ADDR_W-1:0] io_addr_i,
    input  wire  [minisys_io_pkg::IO_DATA_W-1:0] io_wdata_i,
    input  wire                                  io_write_i,
    input  wire                                  io_read_i,
    output logic [minisys_io_pkg::IO_DATA_W-1:0] io_rdata_o,
    io_bus_if.decoder                            bus
);
    import minisys_io_pkg::*;

    logic [5:0] blk;    // Block number field

    assign blk = io_addr_i[IO_ADDR_W-1:4];

    always_comb begin
        case (blk)
            BLK_LED:    bus.sel = IO_LED;
            BLK_SWITCH: bus.sel = IO_SWITCH;
            BLK_TIMER:  bus.sel = IO_TIMER;
            BLK_PWM:    bus.sel = IO_PWM;
            default:    bus.sel = IO_NONE;
        endcase
    end

    // Bit 3 is not part of any register offset
    assign bus.offset = io_addr_i[IO_REG_W-1:0];
    assign bus.wdata  = io_wdata_i;
    assign bus.wr     = io_write_i;
    assign bus.rd     = io_read_i;

    // Read mux, zero outside a read or for blocks with nothing to return
    always_comb begin
        io_rdata_o = '0;
        if (io_read_i) begin
            case (bus.sel)
                IO_SWITCH: io_rdata_o = bus.sw_rdata;
                IO_TIMER:  io_rdata_o = bus.tmr_rdata;
                default:   io_rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/led_switch_port.sv
`timescale 1ns/1ps
`default_nettype none

module led_switch_port (
    input  wire                                 fpga_clk,
    input  wire                                 fpga_rst,
    io_bus_if.ledsw                             bus,
    input  wire  [minisys_io_pkg::SWITCH_W-1:0] switch_i,
    output logic [minisys_io_pkg::LED_W-1:0]    led_o
);
    import minisys_io_pkg::*;

    logic led_wr;

    assign led_wr = bus.wr && (bus.sel == IO_LED);

    // LED bank written as a 16-bit low half and an 8-bit high half
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            led_o <= '0;
        end else if (led_wr) begin
            case (bus.offset)
                LED_LO:  led_o[IO_DATA_W-1:0] <= bus.wdata;
                LED_HI:  led_o[LED_W-1:IO_DATA_W] <= bus.wdata[LED_W-IO_DATA_W-1:0];
                default: ;
            endcase
        end
    end

    // Switch read, high byte zero-extended
    always_comb begin
        case (bus.offset)
            LED_LO:  bus.sw_rdata = switch_i[IO_DATA_W-1:0];
            LED_HI:  bus.sw_rdata = {{(2*IO_DATA_W-SWITCH_W){1'b0}},
                                     switch_i[SWITCH_W-1:IO_DATA_W]};
            default: bus.sw_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/io_timer.sv
`timescale 1ns/1ps
`default_nettype none

module io_timer (
    input  wire       fpga_clk,
    input  wire       fpga_rst,
    io_bus_if.timer   bus
);
    import minisys_io_pkg::*;

    logic [IO_DATA_W-1:0] init_q  [TMR_NUM];  // Reload value
    logic [IO_DATA_W-1:0] cnt_q   [TMR_NUM];
    timer_mode_e          mode_q  [TMR_NUM];
    timer_state_e         state_q [TMR_NUM];
    logic [TMR_NUM-1:0]   done_q;

    logic [TMR_NUM-1:0]   ctrl_wr;
    logic [TMR_NUM-1:0]   cnt_wr;
    logic [TMR_NUM-1:0]   ctrl_rd;
    logic [TMR_NUM-1:0]   expire;             // Running and at zero
    logic [IO_DATA_W-1:0] status  [TMR_NUM];

    function automatic logic [IO_REG_W-1:0] ctrl_off(input int ch);
        return (ch == 0) ? TMR_CTRL0 : TMR_CTRL1;
    endfunction

    function automatic logic [IO_REG_W-1:0] cnt_off(input int ch);
        return (ch == 0) ? TMR_CNT0 : TMR_CNT1;
    endfunction

    always_comb begin
        for (int i = 0; i < TMR_NUM; i++) begin
            ctrl_wr[i] = bus.wr && (bus.sel == IO_TIMER) && (bus.offset == ctrl_off(i));
            cnt_wr[i]  = bus.wr && (bus.sel == IO_TIMER) && (bus.offset == cnt_off(i));
            ctrl_rd[i] = bus.rd && (bus.sel == IO_TIMER) && (bus.offset == ctrl_off(i));
            expire[i]  = (state_q[i] == TMR_RUN) && (cnt_q[i] == '0);
            status[i]  = {{(IO_DATA_W-2){1'b0}}, state_q[i] == TMR_RUN, done_q[i]};
        end
    end

    always_ff @(posedge fpga_clk) begin
        for (int i = 0; i < TMR_NUM; i++) begin
            if (cnt_wr[i]) begin
                init_q[i] <= bus.wdata;
            end
        end
    end

    always_ff @(posedge fpga_clk) begin
        for (int i = 0; i < TMR_NUM; i++) begin
            if (fpga_rst) begin
                mode_q[i]  <= TMR_ONE_SHOT;
                state_q[i] <= TMR_IDLE;
                cnt_q[i]   <= '0;
                done_q[i]  <= 1'b0;
            end else if (ctrl_wr[i]) begin
                mode_q[i] <= timer_mode_e'(bus.wdata[1]);
                done_q[i] <= 1'b0;
                if (bus.wdata[0]) begin
                    state_q[i] <= TMR_RUN;
                    cnt_q[i]   <= init_q[i];    // Load and start
                end else begin
                    state_q[i] <= TMR_IDLE;     // Bit 0 clear stops the channel
                end
            end else if (expire[i]) begin
                done_q[i] <= 1'b1;              // Wins over a status read
                if (mode_q[i] == TMR_REPEAT) begin
                    cnt_q[i] <= init_q[i];
                end else begin
                    state_q[i] <= TMR_IDLE;
                end
            end else begin
                if (state_q[i] == TMR_RUN) begin
                    cnt_q[i] <= cnt_q[i] - 1'b1;
                end
                if (ctrl_rd[i]) begin
                    done_q[i] <= 1'b0;          // Read clears done
                end
            end
        end
    end

    always_comb begin
        case (bus.offset)
            TMR_CTRL0: bus.tmr_rdata = status[0];
            TMR_CTRL1: bus.tmr_rdata = status[1];
            TMR_CNT0:  bus.tmr_rdata = cnt_q[0];
            TMR_CNT1:  bus.tmr_rdata = cnt_q[1];
            default:   bus.tmr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/pwm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_unit (
    input  wire      fpga_clk,
    input  wire      fpga_rst,
    io_bus_if.pwm    bus,
    output logic     pwm_o
);
    import minisys_io_pkg::*;

    logic [IO_DATA_W-1:0] max_q;   // Period minus one
    logic [IO_DATA_W-1:0] cmp_q;   // High cycles per period
    logic                 en_q;
    logic [IO_DATA_W-1:0] cnt_q;
    logic                 pwm_wr;

    assign pwm_wr = bus.wr && (bus.sel == IO_PWM);

    always_ff @(posedge fpga_clk) begin
        if (pwm_wr && bus.offset == PWM_MAX) begin
            max_q <= bus.wdata;
        end
        if (pwm_wr && bus.offset == PWM_CMP) begin
            cmp_q <= bus.wdata;
        end
    end

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            en_q <= 1'b0;
        end else if (pwm_wr && bus.offset == PWM_CTRL) begin
            en_q <= bus.wdata[0];
        end
    end

    // Counter held at zero while disabled
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            cnt_q <= '0;
        end else if (!en_q || cnt_q >= max_q) begin
            cnt_q <= '0;  // Also recovers when the period shrinks mid-run
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign pwm_o = en_q && (cnt_q < cmp_q);

endmodule

`default_nettype wire

//--- verilog/minisys_io.sv
`timescale 1ns/1ps
`default_nettype none

module minisys_io (
    input  wire                                  fpga_clk,
    input  wire                                  fpga_rst,
    // CPU I/O port
    input  wire  [minisys_io_pkg::IO_ADDR_W-1:0] io_addr_i,
    input  wire  [minisys_io_pkg::IO_DATA_W-1:0] io_wdata_i,
    input  wire                                  io_write_i,
    input  wire                                  io_read_i,
    output logic [minisys_io_pkg::IO_DATA_W-1:0] io_rdata_o,
    // Board pins
    input  wire  [minisys_io_pkg::SWITCH_W-1:0]  switch_i,
    output logic [minisys_io_pkg::LED_W-1:0]     led_o,
    output logic                                 pwm_o
);

    io_bus_if bus ();

    io_decoder u_decoder (
        .io_addr_i  (io_addr_i),
        .io_wdata_i (io_wdata_i),
        .io_write_i (io_write_i),
        .io_read_i  (io_read_i),
        .io_rdata_o (io_rdata_o),
        .bus        (bus.decoder)
    );

    led_switch_port u_ledsw (
        .fpga_clk   (fpga_clk),
        .fpga_rst   (fpga_rst),
        .bus        (bus.ledsw),
        .switch_i   (switch_i),
        .led_o      (led_o)
    );

    io_timer u_timer (
        .fpga_clk   (fpga_clk),
        .fpga_rst   (fpga_rst),
        .bus        (bus.timer)
    );

    pwm_unit u_pwm (
        .fpga_clk   (fpga_clk),
        .fpga_rst   (fpga_rst),
        .bus        (bus.pwm),
        .pwm_o      (pwm_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic fpga_clk,
    output logic fpga_rst
);

    initial begin
        fpga_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) fpga_clk = ~fpga_clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        fpga_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge fpga_clk);
        fpga_rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_minisys_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_minisys_io;
    localparam logic [9:0] A_LED_LO = 10'h060;
    localparam logic [9:0] A_LED_HI = 10'h062;
    localparam logic [9:0] A_TCTL0  = 10'h020;  // Timer status and control
    localparam logic [9:0] A_TCTL1  = 10'h022;
    localparam logic [9:0] A_TCNT0  = 10'h024;
    localparam logic [9:0] A_TCNT1  = 10'h026;
    localparam logic [9:0] A_PMAX   = 10'h030;
    localparam logic [9:0] A_PCMP   = 10'h032;
    localparam logic [9:0] A_PCTL   = 10'h034;
    localparam int         TIMEOUT  = 200;      // Cycles or polls per wait

    wire         fpga_clk;
    wire         fpga_rst;
    logic [9:0]  io_addr_i;
    logic [15:0] io_wdata_i;
    logic        io_write_i;
    logic        io_read_i;
    logic [23:0] switch_i;
    wire  [15:0] io_rdata_o;
    wire  [23:0] led_o;
    wire         pwm_o;

    logic [31:0] rng;
    logic [23:0] led_m;         // LED register model
    logic        rd_chk;
    logic [15:0] rd_exp;
    logic        pwm_low;       // PWM disabled
    int          err_val;
    int          err_misc;

    tb_clk_gen #(.PERIOD_NS(4.0), .RST_CYCLES(2)) u_clk (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst)
    );

    minisys_io dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Expected read data from the register model and the switch inputs
    function automatic logic [15:0] ref_rdata(input logic [9:0] addr);
        logic [2:0] off;
        off = addr[2:0];
        case (addr[9:4])
            6'h07:   return (off == 3'd0) ? switch_i[15:0] :
                            (off == 3'd2) ? {8'h00, switch_i[23:16]} : 16'h0000;
            default: return 16'h0000;   // Write-only blocks and idle timers
        endcase
    endfunction

    task automatic flag_mismatch(input string sig, input logic [23:0] got, input logic [23:0] exp);
        err_val++;
        $display("ERR %s: got %h, expected %h", sig, got, exp);
    endtask

    task automatic note_failure(input string msg);
        err_misc++;
        $display("%s", msg);
    endtask

    task automatic write_io(input logic [9:0] addr, input logic [15:0] data);
        @(posedge fpga_clk);
        io_addr_i  <= addr;
        io_wdata_i <= data;
        io_write_i <= 1'b1;
        @(posedge fpga_clk);
        io_write_i <= 1'b0;
    endtask

    // One-cycle read strobe with the data taken mid-cycle
    task automatic read_io(input logic [9:0] addr, input logic chk, output logic [15:0] data);
        @(posedge fpga_clk);
        io_addr_i <= addr;
        io_read_i <= 1'b1;
        rd_chk = chk;
        rd_exp = ref_rdata(addr);
        @(negedge fpga_clk);
        data = io_rdata_o;
        @(posedge fpga_clk);
        io_read_i <= 1'b0;
        rd_chk = 1'b0;
    endtask

    task automatic poll_done(input logic [9:0] addr, output logic [15:0] st);
        st = '0;
        for (int n = 0; n < TIMEOUT && !st[0]; n++) begin
            read_io(addr, 1'b0, st);
        end
        assert (st[0]) else note_failure($sformatf("Timer status at %h never showed done", addr));
    endtask

    always @(negedge fpga_clk) begin
        if (!fpga_rst) begin
            if (io_read_i && rd_chk) begin
                assert (io_rdata_o === rd_exp) else
                    flag_mismatch("io_rdata_o", {8'h00, io_rdata_o}, {8'h00, rd_exp});
            end else if (!io_read_i) begin
                assert (io_rdata_o === 16'h0000) else
                    flag_mismatch("io_rdata_o", {8'h00, io_rdata_o}, 24'h0);
            end
            assert (led_o === led_m) else flag_mismatch("led_o", led_o, led_m);
            assert (!pwm_low || pwm_o === 1'b0) else flag_mismatch("pwm_o", {23'h0, pwm_o}, 24'h0);
        end
    end

    initial begin
        logic [15:0] rd;
        logic [15:0] init;
        logic [15:0] per;
        logic [15:0] cmp;
        logic [15:0] hi;
        logic [15:0] exp_hi;
        int          wait_n;

        io_addr_i  <= '0;
        io_wdata_i <= '0;
        io_write_i <= 1'b0;
        io_read_i  <= 1'b0;
        switch_i   <= '0;
        rng      = 32'h90576ab3;
        led_m    = '0;
        rd_chk   = 1'b0;
        rd_exp   = '0;
        pwm_low  = 1'b1;
        err_val  = 0;
        err_misc = 0;

        wait_n = 0;
        while (fpga_rst !== 1'b0 && wait_n < TIMEOUT) begin
            @(posedge fpga_clk);
            wait_n++;
        end
        assert (fpga_rst === 1'b0) else note_failure("Reset was never released");

        read_io(A_TCTL0, 1'b1, rd);
        read_io(A_TCTL1, 1'b1, rd);
        read_io(A_TCNT0, 1'b1, rd);

        repeat (6) begin
            rng = xorshift32(rng);
            write_io(A_LED_LO, rng[15:0]);
            led_m[15:0] = rng[15:0];
            write_io(A_LED_HI, rng[31:16]);
            led_m[23:16] = rng[23:16];   // Only the low byte lands
        end

        repeat (6) begin
            rng = xorshift32(rng);
            switch_i <= rng[23:0];
            read_io(10'h070, 1'b1, rd);
            read_io(10'h072, 1'b1, rd);
        end
        read_io(10'h074, 1'b1, rd);       // Unmapped offsets
        read_io(10'h3f0, 1'b1, rd);

        // One-shot on channel 0
        rng = xorshift32(rng);
        init = {13'h0, rng[2:0]} + 16'd3;
        write_io(A_TCNT0, init);
        write_io(A_TCTL0, 16'h0001);
        poll_done(A_TCTL0, rd);
        assert (rd === 16'h0001) else flag_mismatch("io_rdata_o", {8'h00, rd}, 24'h000001);
        read_io(A_TCTL0, 1'b1, rd);       // Done cleared by the last poll
        read_io(A_TCNT0, 1'b1, rd);

        // Repeat mode on channel 1
        rng = xorshift32(rng);
        init = {13'h0, rng[2:0]} + 16'd4;
        write_io(A_TCNT1, init);
        write_io(A_TCTL1, 16'h0003);
        repeat (12) begin
            read_io(A_TCNT1, 1'b0, rd);
            assert (rd <= init) else begin
                err_val++;
                $display("ERR io_rdata_o: count %h above initial value %h", rd, init);
            end
        end
        poll_done(A_TCTL1, rd);
        poll_done(A_TCTL1, rd);
        assert (rd[1]) else note_failure("Repeat timer stopped after done");
        write_io(A_TCTL1, 16'h0000);
        read_io(A_TCTL1, 1'b1, rd);

        repeat (3) begin
            rng = xorshift32(rng);
            per = {12'h0, rng[3:0]} + 16'd2;
            cmp = {11'h0, rng[20:16]};
            exp_hi = (cmp < per + 16'd1) ? cmp : per + 16'd1;
            write_io(A_PMAX, per);
            write_io(A_PCMP, cmp);
            pwm_low = 1'b0;
            write_io(A_PCTL, 16'h0001);
            repeat (3) begin
                hi = '0;
                repeat (per + 16'd1) begin
                    @(negedge fpga_clk);
                    hi = hi + {15'h0, pwm_o};
                end
                assert (hi === exp_hi) else flag_mismatch("pwm_o high cycles", {8'h00, hi},
                                                          {8'h00, exp_hi});
            end
            write_io(A_PCTL, 16'h0000);
            pwm_low = 1'b1;
            repeat (2 * per) @(posedge fpga_clk);
        end

        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_misc);
        if (err_val + err_misc == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/minisys_io_pkg.sv
verilog/io_bus_if.sv
verilog/io_decoder.sv
verilog/led_switch_port.sv
verilog/io_timer.sv
verilog/pwm_unit.sv
verilog/minisys_io.sv
verif/tb_clk_gen.sv
verif/tb_minisys_io.sv

//--- Makefile
# Verilator build and run of the minisys I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_minisys_io
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Some tests failed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
